//--- verilog/cpu_mt_pkg.sv
`default_nettype none

package cpu_mt_pkg;

    typedef logic [31:0] word_t;     // Data, instruction and PC
    typedef logic [3:0]  reg_addr_t;
    typedef logic [1:0]  tid_t;
    typedef logic [3:0]  flags_t;    // NZCV, N on top

    localparam word_t NUM_THREADS      = 32'd4;
    localparam word_t THREAD_PC_STRIDE = 32'd256;

    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    localparam reg_addr_t REG_PC = 4'd15;
    localparam reg_addr_t REG_LR = 4'd14;

    // ARM data-processing opcode field, bits 24:21
    typedef enum logic [3:0] {
        OP_AND = 4'h0, OP_EOR = 4'h1, OP_SUB = 4'h2, OP_RSB = 4'h3,
        OP_ADD = 4'h4, OP_ADC = 4'h5, OP_SBC = 4'h6, OP_RSC = 4'h7,
        OP_TST = 4'h8, OP_TEQ = 4'h9, OP_CMP = 4'hA, OP_CMN = 4'hB,
        OP_ORR = 4'hC, OP_MOV = 4'hD, OP_BIC = 4'hE, OP_MVN = 4'hF
    } alu_op_e;

    // Condition field, bits 31:28
    typedef enum logic [3:0] {
        COND_EQ = 4'h0, COND_NE = 4'h1, COND_CS = 4'h2, COND_CC = 4'h3,
        COND_MI = 4'h4, COND_PL = 4'h5, COND_VS = 4'h6, COND_VC = 4'h7,
        COND_HI = 4'h8, COND_LS = 4'h9, COND_GE = 4'hA, COND_LT = 4'hB,
        COND_GT = 4'hC, COND_LE = 4'hD, COND_AL = 4'hE, COND_NV = 4'hF
    } cond_e;

endpackage

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire cpu_mt_pkg::word_t   a_i,
    input  wire cpu_mt_pkg::word_t   b_i,
    input  wire cpu_mt_pkg::alu_op_e op_i,
    input  wire cpu_mt_pkg::flags_t  flags_i,
    output cpu_mt_pkg::word_t        result_o,
    output cpu_mt_pkg::flags_t       flags_o
);

    cpu_mt_pkg::word_t add_x;
    cpu_mt_pkg::word_t add_y;
    logic              add_cin;
    logic              arith;
    logic [32:0]       sum;

    // All arithmetic ops fold onto x + y + cin; C is NOT borrow for subtracts
    always_comb begin
        add_x   = a_i;
        add_y   = b_i;
        add_cin = 1'b0;
        arith   = 1'b1;
        case (op_i)
            cpu_mt_pkg::OP_SUB, cpu_mt_pkg::OP_CMP: begin
                add_y   = ~b_i;
                add_cin = 1'b1;
            end
            cpu_mt_pkg::OP_RSB: begin
                add_x   = b_i;
                add_y   = ~a_i;
                add_cin = 1'b1;
            end
            cpu_mt_pkg::OP_ADD, cpu_mt_pkg::OP_CMN: add_cin = 1'b0;
            cpu_mt_pkg::OP_ADC: add_cin = flags_i[cpu_mt_pkg::FLAG_C];
            cpu_mt_pkg::OP_SBC: begin
                add_y   = ~b_i;
                add_cin = flags_i[cpu_mt_pkg::FLAG_C];
            end
            cpu_mt_pkg::OP_RSC: begin
                add_x   = b_i;
                add_y   = ~a_i;
                add_cin = flags_i[cpu_mt_pkg::FLAG_C];
            end
            default: arith = 1'b0;                         // Logical group
        endcase
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y} + {32'd0, add_cin};

    always_comb begin
        case (op_i)
            cpu_mt_pkg::OP_AND, cpu_mt_pkg::OP_TST: result_o = a_i & b_i;
            cpu_mt_pkg::OP_EOR, cpu_mt_pkg::OP_TEQ: result_o = a_i ^ b_i;
            cpu_mt_pkg::OP_ORR: result_o = a_i | b_i;
            cpu_mt_pkg::OP_MOV: result_o = b_i;
            cpu_mt_pkg::OP_BIC: result_o = a_i & ~b_i;
            cpu_mt_pkg::OP_MVN: result_o = ~b_i;
            default:            result_o = sum[31:0];
        endcase
    end

    // Logical ops keep C and V
    always_comb begin
        flags_o[cpu_mt_pkg::FLAG_N] = result_o[31];
        flags_o[cpu_mt_pkg::FLAG_Z] = (result_o == '0);
        flags_o[cpu_mt_pkg::FLAG_C] = arith ? sum[32] : flags_i[cpu_mt_pkg::FLAG_C];
        flags_o[cpu_mt_pkg::FLAG_V] = arith
            ? ((add_x[31] == add_y[31]) && (sum[31] != add_x[31]))
            : flags_i[cpu_mt_pkg::FLAG_V];
    end

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  wire cpu_mt_pkg::word_t instr_i,
    output cpu_mt_pkg::cond_e      cond_o,
    output cpu_mt_pkg::reg_addr_t  rn_addr_o,
    output cpu_mt_pkg::reg_addr_t  rm_addr_o,
    output cpu_mt_pkg::reg_addr_t  rd_addr_o,
    output cpu_mt_pkg::alu_op_e    alu_op_o,
    output logic                   use_imm_o,
    output cpu_mt_pkg::word_t      imm_o,
    output logic                   set_flags_o,
    output logic                   reg_write_o,
    output logic                   is_branch_o,
    output logic                   branch_link_o
);

    logic              is_dp;
    logic              is_test;
    logic              is_br;
    logic [4:0]        rot_amt;
    logic [63:0]       imm_pair;
    cpu_mt_pkg::word_t dp_imm;
    cpu_mt_pkg::word_t br_offset;

    assign is_test = (instr_i[24:23] == 2'b10);            // TST TEQ CMP CMN
    // Multiplies and extra load/stores share the 00 class, and so do PSR ops with S clear
    assign is_dp = (instr_i[27:26] == 2'b00)
                 && (instr_i[25] || !(instr_i[7] && instr_i[4]))
                 && !(is_test && !instr_i[20]);
    assign is_br = (instr_i[27:25] == 3'b101);

    // imm8 rotated right by twice the rotate field
    assign rot_amt  = {instr_i[11:8], 1'b0};
    assign imm_pair = {2{24'd0, instr_i[7:0]}} >> rot_amt;
    assign dp_imm   = imm_pair[31:0];

    assign br_offset = {{6{instr_i[23]}}, instr_i[23:0], 2'b00};

    assign cond_o    = cpu_mt_pkg::cond_e'(instr_i[31:28]);
    assign alu_op_o  = cpu_mt_pkg::alu_op_e'(instr_i[24:21]);
    assign rn_addr_o = instr_i[19:16];
    assign rm_addr_o = instr_i[3:0];
    assign rd_addr_o = is_br ? cpu_mt_pkg::REG_LR : instr_i[15:12];

    assign use_imm_o     = is_br || (is_dp && instr_i[25]);
    assign imm_o         = is_br ? br_offset : dp_imm;
    assign set_flags_o   = is_dp && instr_i[20];
    assign is_branch_o   = is_br;
    assign branch_link_o = is_br && instr_i[24];
    assign reg_write_o   = (is_dp && !is_test && (instr_i[15:12] != cpu_mt_pkg::REG_PC))
                         || branch_link_o;

endmodule

`default_nettype wire

//--- verilog/thread_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module thread_fetch #(
    parameter cpu_mt_pkg::word_t DONE_PC = 32'h0000_0F00
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    branch_taken_i,
    input  wire cpu_mt_pkg::tid_t  branch_tid_i,
    input  wire cpu_mt_pkg::word_t branch_target_i,
    output cpu_mt_pkg::word_t      fetch_addr_o,
    output cpu_mt_pkg::tid_t       id_tid_o,
    output logic                   id_valid_o,
    output cpu_mt_pkg::word_t      id_pc_plus4_o,
    output logic                   cpu_done_o
);

    cpu_mt_pkg::tid_t  tid_q;                              // Thread owning the fetch slot
    cpu_mt_pkg::word_t pc_q [cpu_mt_pkg::NUM_THREADS];
    cpu_mt_pkg::word_t pc_plus4;

    assign fetch_addr_o = pc_q[tid_q];
    assign pc_plus4     = fetch_addr_o + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tid_q <= '0;
            for (int t = 0; t < cpu_mt_pkg::NUM_THREADS; t++) begin
                pc_q[t] <= cpu_mt_pkg::word_t'(t) * cpu_mt_pkg::THREAD_PC_STRIDE;
            end
        end else begin
            tid_q <= tid_q + 2'd1;
            // A thread parks on DONE_PC so all four can match at once
            if (fetch_addr_o != DONE_PC) begin
                pc_q[tid_q] <= pc_plus4;
            end
            // EX thread is always two slots behind the fetching one
            if (branch_taken_i) begin
                pc_q[branch_tid_i] <= branch_target_i;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        id_tid_o      <= tid_q;
        id_pc_plus4_o <= pc_plus4;
    end

    always_comb begin
        cpu_done_o = 1'b1;
        for (int t = 0; t < cpu_mt_pkg::NUM_THREADS; t++) begin
            if (pc_q[t] != DONE_PC) begin
                cpu_done_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/thread_regfiles.sv
`timescale 1ns/100ps
`default_nettype none

module thread_regfiles (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire cpu_mt_pkg::tid_t      rd_tid_i,
    input  wire cpu_mt_pkg::reg_addr_t rn_addr_i,
    input  wire cpu_mt_pkg::reg_addr_t rm_addr_i,
    output cpu_mt_pkg::word_t          rn_data_o,
    output cpu_mt_pkg::word_t          rm_data_o,
    input  wire                        wr_en_i,
    input  wire cpu_mt_pkg::tid_t      wr_tid_i,
    input  wire cpu_mt_pkg::reg_addr_t wr_addr_i,
    input  wire cpu_mt_pkg::word_t     wr_data_i,
    input  wire cpu_mt_pkg::tid_t      dbg_thread_i,
    input  wire cpu_mt_pkg::reg_addr_t dbg_reg_i,
    output cpu_mt_pkg::word_t          dbg_data_o
);

    localparam int NUM_REGS = 15;                          // R0 to R14, PC is in fetch

    cpu_mt_pkg::word_t regs_q [cpu_mt_pkg::NUM_THREADS][NUM_REGS];

    function automatic cpu_mt_pkg::word_t read_reg(input cpu_mt_pkg::tid_t tid,
                                                   input cpu_mt_pkg::reg_addr_t addr);
        if (addr == cpu_mt_pkg::REG_PC) begin
            return '0;
        end
        return regs_q[tid][addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < cpu_mt_pkg::NUM_THREADS; t++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs_q[t][r] <= '0;
                end
            end
        end else if (wr_en_i && (wr_addr_i != cpu_mt_pkg::REG_PC)) begin
            regs_q[wr_tid_i][wr_addr_i] <= wr_data_i;
        end
    end

    // ID reads and debug reads see different banks
    always_comb begin
        rn_data_o  = read_reg(rd_tid_i, rn_addr_i);
        rm_data_o  = read_reg(rd_tid_i, rm_addr_i);
        dbg_data_o = read_reg(dbg_thread_i, dbg_reg_i);
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        id_valid_i,
    input  wire cpu_mt_pkg::tid_t      id_tid_i,
    input  wire cpu_mt_pkg::word_t     id_pc_plus4_i,
    input  wire cpu_mt_pkg::cond_e     cond_i,
    input  wire cpu_mt_pkg::reg_addr_t rn_addr_i,
    input  wire cpu_mt_pkg::reg_addr_t rm_addr_i,
    input  wire cpu_mt_pkg::reg_addr_t rd_addr_i,
    input  wire cpu_mt_pkg::alu_op_e   alu_op_i,
    input  wire                        use_imm_i,
    input  wire cpu_mt_pkg::word_t     imm_i,
    input  wire                        set_flags_i,
    input  wire                        reg_write_i,
    input  wire                        is_branch_i,
    input  wire                        branch_link_i,
    input  wire cpu_mt_pkg::word_t     rn_data_i,
    input  wire cpu_mt_pkg::word_t     rm_data_i,
    output logic                       branch_taken_o,
    output cpu_mt_pkg::tid_t           branch_tid_o,
    output cpu_mt_pkg::word_t          branch_target_o,
    output logic                       wr_en_o,
    output cpu_mt_pkg::tid_t           wr_tid_o,
    output cpu_mt_pkg::reg_addr_t      wr_addr_o,
    output cpu_mt_pkg::word_t          wr_data_o
);

    cpu_mt_pkg::flags_t    flags_q [cpu_mt_pkg::NUM_THREADS];  // Per-thread NZCV
    cpu_mt_pkg::flags_t    ex_flags;
    cpu_mt_pkg::flags_t    alu_flags;
    cpu_mt_pkg::word_t     pc_plus8;
    cpu_mt_pkg::word_t     rn_val;
    cpu_mt_pkg::word_t     rm_val;
    cpu_mt_pkg::word_t     alu_result;
    logic                  cond_ok;

    logic                  ex_valid;
    logic                  ex_set_flags;
    logic                  ex_reg_write;
    logic                  ex_is_branch;
    logic                  ex_link;
    cpu_mt_pkg::tid_t      ex_tid;
    cpu_mt_pkg::reg_addr_t ex_rd;
    cpu_mt_pkg::alu_op_e   ex_op;
    cpu_mt_pkg::word_t     ex_a;
    cpu_mt_pkg::word_t     ex_b;                           // Immediate, offset or Rm
    cpu_mt_pkg::word_t     ex_pc_plus4;

    function automatic logic cond_pass(input cpu_mt_pkg::cond_e cond,
                                       input cpu_mt_pkg::flags_t f);
        logic n, z, c, v;
        n = f[cpu_mt_pkg::FLAG_N];
        z = f[cpu_mt_pkg::FLAG_Z];
        c = f[cpu_mt_pkg::FLAG_C];
        v = f[cpu_mt_pkg::FLAG_V];
        case (cond)
            cpu_mt_pkg::COND_EQ: return z;
            cpu_mt_pkg::COND_NE: return !z;
            cpu_mt_pkg::COND_CS: return c;
            cpu_mt_pkg::COND_CC: return !c;
            cpu_mt_pkg::COND_MI: return n;
            cpu_mt_pkg::COND_PL: return !n;
            cpu_mt_pkg::COND_VS: return v;
            cpu_mt_pkg::COND_VC: return !v;
            cpu_mt_pkg::COND_HI: return c && !z;
            cpu_mt_pkg::COND_LS: return !c || z;
            cpu_mt_pkg::COND_GE: return n == v;
            cpu_mt_pkg::COND_LT: return n != v;
            cpu_mt_pkg::COND_GT: return !z && (n == v);
            cpu_mt_pkg::COND_LE: return z || (n != v);
            cpu_mt_pkg::COND_AL: return 1'b1;
            default:             return 1'b0;              // NV never issues
        endcase
    endfunction

    // ID side. The thread's previous instruction has already left EX
    assign cond_ok  = cond_pass(cond_i, flags_q[id_tid_i]);
    assign pc_plus8 = id_pc_plus4_i + 32'd4;
    assign rn_val   = (rn_addr_i == cpu_mt_pkg::REG_PC) ? pc_plus8 : rn_data_i;
    assign rm_val   = (rm_addr_i == cpu_mt_pkg::REG_PC) ? pc_plus8 : rm_data_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_set_flags <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_link      <= 1'b0;
        end else begin
            ex_valid     <= id_valid_i && cond_ok;          // Failed condition is a bubble
            ex_set_flags <= set_flags_i;
            ex_reg_write <= reg_write_i;
            ex_is_branch <= is_branch_i;
            ex_link      <= branch_link_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_tid      <= id_tid_i;
        ex_rd       <= rd_addr_i;
        ex_op       <= alu_op_i;
        ex_a        <= rn_val;
        ex_b        <= use_imm_i ? imm_i : rm_val;
        ex_pc_plus4 <= id_pc_plus4_i;
    end

    assign ex_flags = flags_q[ex_tid];

    alu u_alu (
        .a_i      (ex_a),
        .b_i      (ex_b),
        .op_i     (ex_op),
        .flags_i  (ex_flags),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < cpu_mt_pkg::NUM_THREADS; t++) begin
                flags_q[t] <= '0;
            end
        end else if (ex_valid && ex_set_flags) begin
            flags_q[ex_tid] <= alu_flags;
        end
    end

    assign branch_taken_o  = ex_valid && ex_is_branch;
    assign branch_tid_o    = ex_tid;
    assign branch_target_o = ex_pc_plus4 + 32'd4 + ex_b;

    // EX/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= ex_valid && ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wr_tid_o  <= ex_tid;
        wr_addr_o <= ex_rd;
        wr_data_o <= ex_link ? ex_pc_plus4 : alu_result;   // BL return address
    end

endmodule

`default_nettype wire

//--- verilog/cpu_mt_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_mt_top #(
    parameter cpu_mt_pkg::word_t DONE_PC = 32'h0000_0F00
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire cpu_mt_pkg::word_t     i_mem_data_i,
    output cpu_mt_pkg::word_t          i_mem_addr_o,
    input  wire cpu_mt_pkg::tid_t      dbg_thread_i,
    input  wire cpu_mt_pkg::reg_addr_t dbg_reg_i,
    output cpu_mt_pkg::word_t          dbg_data_o,
    output logic                       cpu_done_o
);

    // IF/ID
    wire cpu_mt_pkg::tid_t      id_tid;
    wire                        id_valid;
    wire cpu_mt_pkg::word_t     id_pc_plus4;

    // Decoded fields
    wire cpu_mt_pkg::cond_e     cond;
    wire cpu_mt_pkg::reg_addr_t rn_addr;
    wire cpu_mt_pkg::reg_addr_t rm_addr;
    wire cpu_mt_pkg::reg_addr_t rd_addr;
    wire cpu_mt_pkg::alu_op_e   alu_op;
    wire                        use_imm;
    wire cpu_mt_pkg::word_t     imm;
    wire                        set_flags;
    wire                        reg_write;
    wire                        is_branch;
    wire                        branch_link;
    wire cpu_mt_pkg::word_t     rn_data;
    wire cpu_mt_pkg::word_t     rm_data;

    // Back from EX and WB
    wire                        branch_taken;
    wire cpu_mt_pkg::tid_t      branch_tid;
    wire cpu_mt_pkg::word_t     branch_target;
    wire                        wr_en;
    wire cpu_mt_pkg::tid_t      wr_tid;
    wire cpu_mt_pkg::reg_addr_t wr_addr;
    wire cpu_mt_pkg::word_t     wr_data;

    thread_fetch #(
        .DONE_PC (DONE_PC)
    ) u_thread_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .branch_taken_i  (branch_taken),
        .branch_tid_i    (branch_tid),
        .branch_target_i (branch_target),
        .fetch_addr_o    (i_mem_addr_o),
        .id_tid_o        (id_tid),
        .id_valid_o      (id_valid),
        .id_pc_plus4_o   (id_pc_plus4),
        .cpu_done_o      (cpu_done_o)
    );

    // Synchronous memory read lands the word in ID
    instr_decoder u_instr_decoder (
        .instr_i       (i_mem_data_i),
        .cond_o        (cond),
        .rn_addr_o     (rn_addr),
        .rm_addr_o     (rm_addr),
        .rd_addr_o     (rd_addr),
        .alu_op_o      (alu_op),
        .use_imm_o     (use_imm),
        .imm_o         (imm),
        .set_flags_o   (set_flags),
        .reg_write_o   (reg_write),
        .is_branch_o   (is_branch),
        .branch_link_o (branch_link)
    );

    thread_regfiles u_thread_regfiles (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_tid_i     (id_tid),
        .rn_addr_i    (rn_addr),
        .rm_addr_i    (rm_addr),
        .rn_data_o    (rn_data),
        .rm_data_o    (rm_data),
        .wr_en_i      (wr_en),
        .wr_tid_i     (wr_tid),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .dbg_thread_i (dbg_thread_i),
        .dbg_reg_i    (dbg_reg_i),
        .dbg_data_o   (dbg_data_o)
    );

    execute_stage u_execute_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_valid_i      (id_valid),
        .id_tid_i        (id_tid),
        .id_pc_plus4_i   (id_pc_plus4),
        .cond_i          (cond),
        .rn_addr_i       (rn_addr),
        .rm_addr_i       (rm_addr),
        .rd_addr_i       (rd_addr),
        .alu_op_i        (alu_op),
        .use_imm_i       (use_imm),
        .imm_i           (imm),
        .set_flags_i     (set_flags),
        .reg_write_i     (reg_write),
        .is_branch_i     (is_branch),
        .branch_link_i   (branch_link),
        .rn_data_i       (rn_data),
        .rm_data_i       (rm_data),
        .branch_taken_o  (branch_taken),
        .branch_tid_o    (branch_tid),
        .branch_target_o (branch_target),
        .wr_en_o         (wr_en),
        .wr_tid_o        (wr_tid),
        .wr_addr_o       (wr_addr),
        .wr_data_o       (wr_data)
    );

endmodule

`default_nettype wire

//--- verification/cpu_mt_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_mt_assertions (
    input wire                        clk,
    input wire                        rst_n,
    input wire                        ex_valid_i,
    input wire cpu_mt_pkg::tid_t      ex_tid_i,
    input wire                        branch_taken_i,
    input wire                        wr_en_i,
    input wire cpu_mt_pkg::tid_t      wr_tid_i,
    input wire cpu_mt_pkg::reg_addr_t wr_addr_i
);

    int fail_count = 0;                                    // Read by the testbench at the end

    // WB always holds the thread that left EX one slot earlier
    wb_ex_thread_differ: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en_i |-> (wr_tid_i != ex_tid_i))
        else begin
            $error("Write strobe high with the tid of the EX thread");
            fail_count++;
        end

    branch_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        branch_taken_i |-> ex_valid_i)
        else begin
            $error("Branch strobe high while the ID/EX valid bit is low");
            fail_count++;
        end

    no_pc_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en_i |-> (wr_addr_i != cpu_mt_pkg::REG_PC))
        else begin
            $error("Write strobe high with R15 as destination");
            fail_count++;
        end

endmodule

bind execute_stage cpu_mt_assertions u_cpu_mt_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid),
    .ex_tid_i       (ex_tid),
    .branch_taken_i (branch_taken_o),
    .wr_en_i        (wr_en_o),
    .wr_tid_i       (wr_tid_o),
    .wr_addr_i      (wr_addr_o)
);

`default_nettype wire

//--- verification/tb_cpu_mt.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_mt;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 10;
    localparam int RAND_SEED  = 67337;
    localparam int MEM_WORDS  = 1024;                      // 4 KiB
    localparam int DONE_LIMIT = 4 * 40;                    // Cycles allowed per test run
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (4 * 40 + 10);

    logic                      clk;
    logic                      rst_n;
    cpu_mt_pkg::word_t         i_mem_data;
    cpu_mt_pkg::word_t         i_mem_addr;
    cpu_mt_pkg::tid_t          dbg_thread;
    cpu_mt_pkg::reg_addr_t     dbg_reg;
    cpu_mt_pkg::word_t         dbg_data;
    logic                      cpu_done;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] fetch_addr_q;
    logic [31:0] model_regs [4][15];
    int          fetch_count [4];                          // Fetches per thread up to 0xF00
    int          errors;
    int          checks;

    cpu_mt_top #(
        .DONE_PC (32'h0000_0F00)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_mem_data_i (i_mem_data),
        .i_mem_addr_o (i_mem_addr),
        .dbg_thread_i (dbg_thread),
        .dbg_reg_i    (dbg_reg),
        .dbg_data_o   (dbg_data),
        .cpu_done_o   (cpu_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Address captured on the rising edge, word presented on the falling edge
    always @(posedge clk) fetch_addr_q <= i_mem_addr;
    always @(negedge clk) i_mem_data <= imem[fetch_addr_q[11:2]];

    function automatic logic [3:0] pick_cond();
        return ($urandom % 2) ? 4'hE : 4'($urandom % 16);
    endfunction

    function automatic logic [3:0] pick_reg();
        return ($urandom % 8 == 0) ? 4'd15 : 4'($urandom % 14);
    endfunction

    function automatic logic [31:0] random_dp();
        logic [3:0] op;
        logic       s;
        op = 4'($urandom % 16);
        s  = (op[3:2] == 2'b10) ? 1'b1 : 1'($urandom % 2);  // Compare ops always set S
        if ($urandom % 2) begin
            return {pick_cond(), 3'b001, op, s, pick_reg(), pick_reg(),
                    4'($urandom % 16), 8'($urandom % 256)};
        end
        return {pick_cond(), 3'b000, op, s, pick_reg(), pick_reg(), 8'd0, pick_reg()};
    endfunction

    task automatic build_image();
        int          n;
        int          k;
        int          base;
        logic [31:0] off;
        for (int w = 0; w < MEM_WORDS; w++) begin
            imem[w] = 32'hF000_0000 | w;                   // NV condition, never executes
        end
        for (int t = 0; t < 4; t++) begin
            base = t * 64;
            n    = 8 + $urandom % 17;
            for (int i = 0; i < n - 1; i++) begin
                if ((i < n - 2) && ($urandom % 6 == 0)) begin
                    k = 1 + $urandom % (((n - 2 - i) < 3) ? (n - 2 - i) : 3);
                    imem[base + i] = {pick_cond(), 3'b101, 1'($urandom % 2), 24'(k - 1)};
                end else begin
                    imem[base + i] = random_dp();
                end
            end
            off = (32'hF00 - 32'((base + n - 1) * 4) - 32'd8) >> 2;
            imem[base + n - 1] = {8'hEA, off[23:0]};       // B 0xF00
        end
        imem[32'hF00 >> 2] = 32'hEAFF_FFFE;                // B to itself
    endtask

    function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
        logic base;
        case (cond[3:1])
            3'd0:    base = f[2];
            3'd1:    base = f[1];
            3'd2:    base = f[3];
            3'd3:    base = f[0];
            3'd4:    base = f[1] && !f[2];
            3'd5:    base = (f[3] == f[0]);
            3'd6:    base = !f[2] && (f[3] == f[0]);
            default: base = 1'b1;
        endcase
        return cond[0] ? !base : base;                     // Odd codes invert
    endfunction

    // Returns {C, V, result}
    function automatic logic [33:0] add_ref(input logic [31:0] x, input logic [31:0] y,
                                            input logic cin);
        logic [63:0] u;
        longint      s;
        u = {32'd0, x} + {32'd0, y} + {63'd0, cin};
        s = longint'($signed(x)) + longint'($signed(y)) + longint'({63'd0, cin});
        return {u[32], s != longint'($signed(u[31:0])), u[31:0]};
    endfunction

    function automatic logic [33:0] sub_ref(input logic [31:0] x, input logic [31:0] y,
                                            input logic borrow);
        logic [31:0] r;
        longint      s;
        r = x - y - {31'd0, borrow};
        s = longint'($signed(x)) - longint'($signed(y)) - longint'({63'd0, borrow});
        return {{32'd0, x} >= ({32'd0, y} + {63'd0, borrow}), s != longint'($signed(r)), r};
    endfunction

    task automatic exec_dp(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                           input logic [3:0] f_in, output logic [31:0] res,
                           output logic [3:0] f_out);
        logic [33:0] cvr;
        cvr = {f_in[1], f_in[0], 32'd0};                   // Logical ops keep C and V
        case (op)
            4'h0, 4'h8: cvr[31:0] = a & b;
            4'h1, 4'h9: cvr[31:0] = a ^ b;
            4'hC:       cvr[31:0] = a | b;
            4'hD:       cvr[31:0] = b;
            4'hE:       cvr[31:0] = a & ~b;
            4'hF:       cvr[31:0] = ~b;
            4'h4, 4'hB: cvr = add_ref(a, b, 1'b0);
            4'h5:       cvr = add_ref(a, b, f_in[1]);
            4'h2, 4'hA: cvr = sub_ref(a, b, 1'b0);
            4'h6:       cvr = sub_ref(a, b, !f_in[1]);
            4'h3:       cvr = sub_ref(b, a, 1'b0);
            default:    cvr = sub_ref(b, a, !f_in[1]);     // RSC
        endcase
        res   = cvr[31:0];
        f_out = {res[31], res == 32'd0, cvr[33], cvr[32]};
    endtask

    function automatic logic [31:0] operand(input int t, input logic [3:0] idx,
                                            input logic [31:0] pc);
        return (idx == 4'd15) ? pc + 32'd8 : model_regs[t][idx];
    endfunction

    function automatic logic [31:0] rotate_imm(input logic [7:0] imm8, input logic [3:0] rot);
        logic [31:0] x;
        int          amt;
        x   = {24'd0, imm8};
        amt = 2 * rot;
        return (x >> amt) | (x << (32 - amt));
    endfunction

    // Instruction-level run of one thread's program
    task automatic run_model(input int t);
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] b;
        logic [31:0] res;
        logic [3:0]  nzcv;
        logic [3:0]  nzcv_new;
        int          steps;
        for (int r = 0; r < 15; r++) begin
            model_regs[t][r] = '0;
        end
        nzcv  = '0;
        pc    = 32'(t * 256);
        steps = 0;
        while ((pc != 32'hF00) && (steps < 64)) begin
            ins = imem[pc[11:2]];
            steps++;
            if (!cond_holds(ins[31:28], nzcv)) begin
                pc = pc + 32'd4;
            end else if (ins[27:25] == 3'b101) begin
                if (ins[24]) model_regs[t][14] = pc + 32'd4;   // BL return address
                pc = pc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
            end else begin
                b = ins[25] ? rotate_imm(ins[7:0], ins[11:8]) : operand(t, ins[3:0], pc);
                exec_dp(ins[24:21], operand(t, ins[19:16], pc), b, nzcv, res, nzcv_new);
                if (ins[20]) nzcv = nzcv_new;
                if ((ins[24:23] != 2'b10) && (ins[15:12] != 4'd15)) begin
                    model_regs[t][ins[15:12]] = res;
                end
                pc = pc + 32'd4;
            end
        end
        fetch_count[t] = steps;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic run_test(input int num);
        int errs_before;
        int checks_before;
        int cyc;
        int expect_cyc;
        errs_before   = errors;
        checks_before = checks;
        @(negedge clk);
        rst_n = 1'b0;
        build_image();
        expect_cyc = 0;
        for (int t = 0; t < 4; t++) begin
            run_model(t);
            if (4 * (fetch_count[t] - 1) + t + 3 > expect_cyc) begin
                expect_cyc = 4 * (fetch_count[t] - 1) + t + 3;  // Final B lands in EX + 1
            end
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        cyc   = 0;
        check_value("cpu_done_o", {31'd0, cpu_done}, 32'd0);
        while (!cpu_done && (cyc < DONE_LIMIT)) begin
            if (cyc < 4) check_value("i_mem_addr_o", i_mem_addr, 32'(cyc * 256));
            @(negedge clk);
            cyc++;
        end
        if (!cpu_done) begin
            $display("Test %0d: cpu_done_o did not rise within %0d cycles", num, DONE_LIMIT);
            errors++;
        end else begin
            check_value("cpu_done_o rise cycle", 32'(cyc), 32'(expect_cyc));
            for (int t = 0; t < 4; t++) begin
                for (int r = 0; r < 15; r++) begin
                    @(negedge clk);
                    dbg_thread = 2'(t);
                    dbg_reg    = 4'(r);
                    @(posedge clk);
                    check_value($sformatf("dbg_data_o (thread %0d R%0d)", t, r), dbg_data,
                                model_regs[t][r]);
                end
            end
        end
        $display("Test %0d done: %0d checks, %0d errors", num, checks - checks_before,
                 errors - errs_before);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        i_mem_data = '0;
        dbg_thread = '0;
        dbg_reg    = '0;
        errors     = 0;
        checks     = 0;
        void'($urandom(RAND_SEED));
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_test(n);
        end
        errors = errors + DUT.u_execute_stage.u_cpu_mt_assertions.fail_count;
        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/cpu_mt_pkg.sv
verilog/alu.sv
verilog/instr_decoder.sv
verilog/thread_fetch.sv
verilog/thread_regfiles.sv
verilog/execute_stage.sv
verilog/cpu_mt_top.sv
verification/cpu_mt_assertions.sv
verification/tb_cpu_mt.sv

//--- Bender.yml
package:
  name: cpu_mt

sources:
  - verilog/cpu_mt_pkg.sv
  - verilog/alu.sv
  - verilog/instr_decoder.sv
  - verilog/thread_fetch.sv
  - verilog/thread_regfiles.sv
  - verilog/execute_stage.sv
  - verilog/cpu_mt_top.sv
  - target: simulation
    files:
      - verification/cpu_mt_assertions.sv
      - verification/tb_cpu_mt.sv
